// File: hdl/frontSlice_params.svh
`ifndef FRONTSLICE_PARAMS_SVH
`define FRONTSLICE_PARAMS_SVH

// 32 gprs plus hi and lo.
`define FS_ARCH_REGS 34
`define FS_AREG_W 6

`define FS_PHYS_REGS 64
`define FS_PTAG_W 6

// tags below this one form the reset identity map.
`define FS_FIRST_FREE 34

`endif

// File: hdl/frontSlicePkg.sv
package frontSlicePkg;

`include "frontSlice_params.svh"

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [5:0]  funct;
    } rFmtFields;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFmtFields;

    typedef union packed {
        rFmtFields rFmt;
        iFmtFields iFmt;
    } instrWord;

    typedef struct packed {
        instrWord instr0;
        instrWord instr1;
        logic     valid0;
        logic     valid1;
    } instrPair;

    typedef enum logic [2:0] {
        uOpAlu,
        uOpAluImm,
        uOpLoad,
        uOpStore,
        uOpBranch,
        uOpMulHi,
        uOpMulLo,
        uOpBubble
    } uOpKind;

    typedef struct packed {
        uOpKind                 kind;
        logic [`FS_AREG_W-1:0]  src0;
        logic [`FS_AREG_W-1:0]  src1;
        logic [`FS_AREG_W-1:0]  dst;
        logic                   dstWe;
        logic                   isBranch;
        logic                   causeExc; // sticky, rides along to retire.
        logic                   valid;
    } uOp;

    typedef struct packed {
        uOp slot0;
        uOp slot1;
    } uOpPair;

    typedef struct packed {
        uOpKind                 kind;
        logic [`FS_PTAG_W-1:0]  psrc0;
        logic [`FS_PTAG_W-1:0]  psrc1;
        logic [`FS_PTAG_W-1:0]  pdst;
        logic                   dstWe;
        logic                   causeExc;
        logic                   valid;
    } renamedOp;

    typedef struct packed {
        renamedOp slot0;
        renamedOp slot1;
    } renamedPair;

    typedef struct packed {
        logic flush;
        logic pause;
        logic stall;
    } stageCtrl;

endpackage

// File: hdl/instrDecoder.sv
`timescale 1ns/1ns
`include "frontSlice_params.svh"

module instrDecoder (
    input  logic                    clk,
    input  logic                    rstN,
    input  frontSlicePkg::stageCtrl ctrl,
    input  frontSlicePkg::instrWord instr,
    input  logic                    instrValid,
    output frontSlicePkg::uOpPair   decoded
);

    localparam int unsigned AregW = `FS_AREG_W;
    localparam logic [AregW-1:0] HiReg = AregW'(`FS_ARCH_REGS - 2);
    localparam logic [AregW-1:0] LoReg = AregW'(`FS_ARCH_REGS - 1);

    localparam logic [5:0] OpSpecial = 6'h00;
    localparam logic [5:0] FnMult    = 6'h18;
    localparam logic [5:0] FnMultu   = 6'h19;

    frontSlicePkg::uOpPair nextPair;
    logic [AregW-1:0]      rsIdx;
    logic [AregW-1:0]      rtIdx;
    logic [AregW-1:0]      rdIdx;

    assign rsIdx = AregW'(instr.rFmt.rs);
    assign rtIdx = AregW'(instr.iFmt.rt); // i-format target.
    assign rdIdx = AregW'(instr.rFmt.rd);

    always_comb begin
        nextPair = '0;
        nextPair.slot0.valid = instrValid;
        nextPair.slot0.src0 = rsIdx;
        case (instr.rFmt.opcode)
            OpSpecial: begin
                nextPair.slot0.src1 = rtIdx;
                if (instr.rFmt.funct == FnMult || instr.rFmt.funct == FnMultu) begin
                    nextPair.slot0.kind = frontSlicePkg::uOpMulHi;
                    nextPair.slot0.dst = HiReg;
                    nextPair.slot0.dstWe = 1'b1;
                    nextPair.slot1 = nextPair.slot0; // same sources, lo half.
                    nextPair.slot1.kind = frontSlicePkg::uOpMulLo;
                    nextPair.slot1.dst = LoReg;
                end else begin
                    nextPair.slot0.kind = frontSlicePkg::uOpAlu;
                    nextPair.slot0.dst = rdIdx;
                    nextPair.slot0.dstWe = (rdIdx != '0);
                end
            end
            6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
                nextPair.slot0.kind = frontSlicePkg::uOpAluImm;
                nextPair.slot0.dst = rtIdx;
                nextPair.slot0.dstWe = (rtIdx != '0);
            end
            6'h20, 6'h21, 6'h23, 6'h24, 6'h25: begin
                nextPair.slot0.kind = frontSlicePkg::uOpLoad;
                nextPair.slot0.dst = rtIdx;
                nextPair.slot0.dstWe = (rtIdx != '0);
            end
            6'h28, 6'h29, 6'h2b: begin
                nextPair.slot0.kind = frontSlicePkg::uOpStore;
                nextPair.slot0.src1 = rtIdx; // store data.
            end
            6'h04, 6'h05: begin
                nextPair.slot0.kind = frontSlicePkg::uOpBranch;
                nextPair.slot0.src1 = rtIdx;
                nextPair.slot0.isBranch = 1'b1;
            end
            default: begin
                nextPair.slot0.kind = frontSlicePkg::uOpAlu;
                nextPair.slot0.causeExc = 1'b1; // reserved instruction.
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN || ctrl.flush) begin
            decoded <= '0;
        end else if (!(ctrl.pause || ctrl.stall)) begin
            decoded <= nextPair;
        end
    end

    slot1NeedsSlot0: assert property (@(posedge clk) disable iff (!rstN)
        decoded.slot1.valid |-> decoded.slot0.valid);

endmodule

// File: hdl/decodeRenameRegs.sv
`timescale 1ns/1ns

module decodeRenameRegs (
    input  logic                    clk,
    input  logic                    rstN,
    input  frontSlicePkg::stageCtrl ctrl,
    input  frontSlicePkg::uOpPair   decode0,
    input  frontSlicePkg::uOpPair   decode1,
    output frontSlicePkg::uOpPair   renameIn,
    output logic                    pauseReq
);

    localparam frontSlicePkg::uOp Bubble = '{
        kind:     frontSlicePkg::uOpBubble,
        src0:     '0,
        src1:     '0,
        dst:      '0,
        dstWe:    1'b0,
        isBranch: 1'b0,
        causeExc: 1'b0,
        valid:    1'b1
    };

    frontSlicePkg::uOp uOp0;
    frontSlicePkg::uOp uOp1;
    frontSlicePkg::uOp uOp2;
    frontSlicePkg::uOp uOp3;
    logic              full;
    logic              lastIsFull;

    // four ops held, only two fit this cycle.
    assign full = (uOp1.valid || uOp3.valid) && !lastIsFull;
    assign pauseReq = full;

    always_ff @(posedge clk) begin
        if (!rstN || ctrl.flush) begin
            uOp0 <= '0;
            uOp1 <= '0;
            uOp2 <= '0;
            uOp3 <= '0;
            lastIsFull <= 1'b0;
        end else if (ctrl.stall) begin
            lastIsFull <= lastIsFull; // frozen with the rest.
        end else if (ctrl.pause || full) begin
            lastIsFull <= 1'b1; // b half goes out next.
        end else begin
            uOp0 <= decode0.slot0;
            uOp1 <= decode0.slot1;
            uOp2 <= decode1.slot0;
            uOp3 <= decode1.slot1;
            lastIsFull <= 1'b0;
        end
    end

    always_comb begin
        if (lastIsFull) begin
            renameIn.slot0 = uOp2;
            renameIn.slot1 = uOp3;
        end else if (full) begin
            renameIn.slot0 = uOp0;
            renameIn.slot1 = uOp1.valid ? uOp1 : Bubble;
        end else begin
            renameIn.slot0 = uOp0;
            renameIn.slot1 = uOp2;
        end
    end

    noBackToBackPause: assert property (@(posedge clk) disable iff (!rstN)
        pauseReq && !ctrl.stall && !ctrl.flush |=> !pauseReq);

endmodule

// File: hdl/tagCounter.sv
`timescale 1ns/1ns
`include "frontSlice_params.svh"

module tagCounter (
    input  logic                    clk,
    input  logic                    rstN,
    input  frontSlicePkg::stageCtrl ctrl,
    input  logic [1:0]              allocCount,
    output logic [`FS_PTAG_W-1:0]   nextTag0,
    output logic [`FS_PTAG_W-1:0]   nextTag1
);

    localparam int unsigned TagW = `FS_PTAG_W;
    localparam logic [TagW-1:0] FirstTag = TagW'(`FS_FIRST_FREE);
    localparam logic [TagW-1:0] LastTag = TagW'(`FS_PHYS_REGS - 1);

    logic [TagW-1:0] allocPtr;
    logic [TagW-1:0] afterTag1;

    assign nextTag0 = allocPtr;
    assign nextTag1 = (allocPtr == LastTag) ? FirstTag : allocPtr + 1'b1;
    assign afterTag1 = (nextTag1 == LastTag) ? FirstTag : nextTag1 + 1'b1;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            allocPtr <= FirstTag;
        end else if (!ctrl.stall) begin
            case (allocCount)
                2'd1:    allocPtr <= nextTag1;
                2'd2:    allocPtr <= afterTag1;
                default: allocPtr <= allocPtr;
            endcase
        end
    end

    allocCountRange: assert property (@(posedge clk) disable iff (!rstN)
        allocCount <= 2'd2);

endmodule

// File: hdl/renameMap.sv
`timescale 1ns/1ns
`include "frontSlice_params.svh"

module renameMap (
    input  logic                      clk,
    input  logic                      rstN,
    input  frontSlicePkg::stageCtrl   ctrl,
    input  frontSlicePkg::uOpPair     renameIn,
    input  logic [`FS_PTAG_W-1:0]     nextTag0,
    input  logic [`FS_PTAG_W-1:0]     nextTag1,
    output logic [1:0]                allocCount,
    output frontSlicePkg::renamedPair renamed
);

    localparam int unsigned TagW = `FS_PTAG_W;

    logic [TagW-1:0]         mapTable [`FS_ARCH_REGS];
    frontSlicePkg::renamedOp op0;
    frontSlicePkg::renamedOp op1;
    logic                    we0;
    logic                    we1;
    logic                    update;

    assign update = !ctrl.stall && !ctrl.flush;
    assign we0 = renameIn.slot0.valid && renameIn.slot0.dstWe;
    assign we1 = renameIn.slot1.valid && renameIn.slot1.dstWe; // bubbles never write.
    assign allocCount = update ? (2'(we0) + 2'(we1)) : 2'd0;

    always_comb begin
        op0.kind = renameIn.slot0.kind;
        op0.psrc0 = mapTable[renameIn.slot0.src0];
        op0.psrc1 = mapTable[renameIn.slot0.src1];
        op0.pdst = we0 ? nextTag0 : '0;
        op0.dstWe = we0;
        op0.causeExc = renameIn.slot0.causeExc;
        op0.valid = renameIn.slot0.valid;

        op1.kind = renameIn.slot1.kind;
        op1.psrc0 = mapTable[renameIn.slot1.src0];
        op1.psrc1 = mapTable[renameIn.slot1.src1];
        if (we0 && renameIn.slot0.dst == renameIn.slot1.src0) begin
            op1.psrc0 = op0.pdst; // raw inside the pair.
        end
        if (we0 && renameIn.slot0.dst == renameIn.slot1.src1) begin
            op1.psrc1 = op0.pdst;
        end
        op1.pdst = we1 ? (we0 ? nextTag1 : nextTag0) : '0;
        op1.dstWe = we1;
        op1.causeExc = renameIn.slot1.causeExc;
        op1.valid = renameIn.slot1.valid;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `FS_ARCH_REGS; i++) begin
                mapTable[i] <= TagW'(i); // identity map.
            end
        end else if (update) begin
            if (we0) begin
                mapTable[renameIn.slot0.dst] <= op0.pdst;
            end
            if (we1) begin
                mapTable[renameIn.slot1.dst] <= op1.pdst; // younger wins.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN || ctrl.flush) begin
            renamed <= '0;
        end else if (!ctrl.stall) begin
            renamed.slot0 <= op0;
            renamed.slot1 <= op1;
        end
    end

endmodule

// File: hdl/pipeCtrl.sv
`timescale 1ns/1ns

module pipeCtrl (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    flushIn,
    input  logic                    stallIn,
    input  logic                    pauseReq,
    output frontSlicePkg::stageCtrl decodeCtrl,
    output frontSlicePkg::stageCtrl renameCtrl,
    output logic                    inReady
);

    typedef enum logic [1:0] {
        stRun,
        stMergeHold,
        stStalled
    } ctrlState;

    ctrlState state;
    ctrlState nextState;
    logic     stall;

    assign stall = stallIn && !flushIn; // flush wins.

    always_comb begin
        nextState = state;
        case (state)
            stRun: begin
                if (stallIn) begin
                    nextState = stStalled;
                end else if (pauseReq) begin
                    nextState = stMergeHold;
                end
            end
            stMergeHold: begin
                nextState = stallIn ? stStalled : stRun; // second half leaves now.
            end
            default: begin
                if (!stallIn) begin
                    nextState = pauseReq ? stMergeHold : stRun;
                end
            end
        endcase
        if (flushIn) begin
            nextState = stRun;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stStalled; // opens one cycle after reset.
        end else begin
            state <= nextState;
        end
    end

    assign inReady = (state != stStalled) && (nextState == stRun) && !flushIn;

    assign decodeCtrl.flush = flushIn;
    assign decodeCtrl.pause = pauseReq && !flushIn;
    assign decodeCtrl.stall = stall;

    assign renameCtrl.flush = flushIn;
    assign renameCtrl.pause = 1'b0;
    assign renameCtrl.stall = stall;

endmodule

// File: hdl/frontSlice.sv
`timescale 1ns/1ns
`include "frontSlice_params.svh"

module frontSlice (
    input  logic                      clk,
    input  logic                      rstN,
    input  frontSlicePkg::instrPair   inPair,
    input  logic                      flushIn,
    input  logic                      stallIn,
    output logic                      inReady,
    output frontSlicePkg::renamedPair outPair
);

    frontSlicePkg::stageCtrl decodeCtrl;
    frontSlicePkg::stageCtrl renameCtrl;
    frontSlicePkg::uOpPair   decoded0;
    frontSlicePkg::uOpPair   decoded1;
    frontSlicePkg::uOpPair   renameIn;
    logic                    pauseReq;
    logic                    accept0;
    logic                    accept1;
    logic [`FS_PTAG_W-1:0]   nextTag0;
    logic [`FS_PTAG_W-1:0]   nextTag1;
    logic [1:0]              allocCount;

    // nothing enters while upstream is not ready.
    assign accept0 = inPair.valid0 && inReady;
    assign accept1 = inPair.valid1 && inReady;

    instrDecoder decoder0_i (
        .clk        (clk),
        .rstN       (rstN),
        .ctrl       (decodeCtrl),
        .instr      (inPair.instr0),
        .instrValid (accept0),
        .decoded    (decoded0)
    );

    instrDecoder decoder1_i (
        .clk        (clk),
        .rstN       (rstN),
        .ctrl       (decodeCtrl),
        .instr      (inPair.instr1),
        .instrValid (accept1),
        .decoded    (decoded1)
    );

    decodeRenameRegs mergeRegs_i (
        .clk      (clk),
        .rstN     (rstN),
        .ctrl     (decodeCtrl),
        .decode0  (decoded0),
        .decode1  (decoded1),
        .renameIn (renameIn),
        .pauseReq (pauseReq)
    );

    tagCounter tagCounter_i (
        .clk        (clk),
        .rstN       (rstN),
        .ctrl       (renameCtrl),
        .allocCount (allocCount),
        .nextTag0   (nextTag0),
        .nextTag1   (nextTag1)
    );

    renameMap renameMap_i (
        .clk        (clk),
        .rstN       (rstN),
        .ctrl       (renameCtrl),
        .renameIn   (renameIn),
        .nextTag0   (nextTag0),
        .nextTag1   (nextTag1),
        .allocCount (allocCount),
        .renamed    (outPair)
    );

    pipeCtrl pipeCtrl_i (
        .clk        (clk),
        .rstN       (rstN),
        .flushIn    (flushIn),
        .stallIn    (stallIn),
        .pauseReq   (pauseReq),
        .decodeCtrl (decodeCtrl),
        .renameCtrl (renameCtrl),
        .inReady    (inReady)
    );

endmodule

// File: dv/frontSliceTb.sv
`timescale 1ns/1ns

module frontSliceTb;

    logic                      clk = 1'b0;
    logic                      rstN;
    frontSlicePkg::instrPair   inPair;
    logic                      flushIn;
    logic                      stallIn;
    logic                      inReady;
    frontSlicePkg::renamedPair outPair;

    frontSlicePkg::instrPair   inQ[$];
    bit                        flushQ[$];
    int                        drainQ[$];
    frontSlicePkg::renamedOp   expQ[$];
    frontSlicePkg::renamedPair lastOut = '0;
    int                        gotCount = 0;
    int                        cycleCount = 0;
    int                        cycleLimit = 0;
    int                        pauseBudget = 0;
    int                        pauseCount = 0;
    bit                        started = 1'b0;
    bit                        prevStall = 1'b0;
    bit                        seenReady = 1'b0;
    bit                        prevPauseLow = 1'b0;

    frontSlice frontSlice_i (
        .clk     (clk),
        .rstN    (rstN),
        .inPair  (inPair),
        .flushIn (flushIn),
        .stallIn (stallIn),
        .inReady (inReady),
        .outPair (outPair)
    );

    always #5 clk = ~clk;

    task automatic checkRenamed(frontSlicePkg::renamedOp got, frontSlicePkg::renamedOp exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: op %0d got kind %0d src %0d/%0d dst %0d we %0b exc %0b",
                $time, gotCount, got.kind, got.psrc0, got.psrc1, got.pdst, got.dstWe,
                got.causeExc);
            $display("MISMATCH at %0t: expected kind %0d src %0d/%0d dst %0d we %0b exc %0b",
                $time, exp.kind, exp.psrc0, exp.psrc1, exp.pdst, exp.dstWe, exp.causeExc);
            $display("Regression failed");
            $fatal(1, "renamed op differs");
        end
    endtask

    task automatic checkIdle(frontSlicePkg::renamedPair got);
        if (got !== '0) begin
            $display("MISMATCH at %0t: output not empty after flush, got %h", $time, got);
            $display("Regression failed");
            $fatal(1, "output not cleared");
        end
    endtask

    task automatic checkHold(frontSlicePkg::renamedPair got, frontSlicePkg::renamedPair held);
        if (got !== held) begin
            $display("MISMATCH at %0t: output moved under stall, got %h held %h",
                $time, got, held);
            $display("Regression failed");
            $fatal(1, "output not held");
        end
    endtask

    task automatic checkReady(logic got, logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: inReady got %b expected %b outside a stall or pause",
                $time, got, exp);
            $display("Regression failed");
            $fatal(1, "inReady differs");
        end
    endtask

    task automatic takeOp(frontSlicePkg::renamedOp op);
        if (gotCount >= expQ.size()) begin
            $display("valid micro-op at %0t after the expected stream ended", $time);
            $display("Regression failed");
            $fatal(1, "extra output");
        end else begin
            checkRenamed(op, expQ[gotCount]);
            gotCount++;
        end
    endtask

    task automatic readCases();
        int                      fd;
        int                      n;
        string                   tag;
        string                   rest;
        logic [31:0]             w0;
        logic [31:0]             w1;
        int                      v0;
        int                      v1;
        int                      k;
        int                      s0;
        int                      s1;
        int                      d;
        int                      we;
        int                      ex;
        frontSlicePkg::instrPair p;
        frontSlicePkg::renamedOp e;
        fd = $fopen("dv/frontSlice_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the cases file dv/frontSlice_cases.txt");
            $display("Regression failed");
            $fatal(1, "no cases");
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "I" || tag == "F") begin
                n = $fscanf(fd, "%h %h %d %d", w0, w1, v0, v1);
                if (n != 4) begin
                    $display("malformed input line in the cases file");
                    $display("Regression failed");
                    $fatal(1, "bad cases file");
                end
                p.instr0 = w0;
                p.instr1 = w1;
                p.valid0 = v0[0];
                p.valid1 = v1[0];
                inQ.push_back(p);
                flushQ.push_back(tag == "F");
                drainQ.push_back(expQ.size()); // ops due before this pair.
            end else if (tag == "E") begin
                n = $fscanf(fd, "%d %d %d %d %d %d", k, s0, s1, d, we, ex);
                if (n != 6) begin
                    $display("malformed expected line in the cases file");
                    $display("Regression failed");
                    $fatal(1, "bad cases file");
                end
                e.kind = frontSlicePkg::uOpKind'(k);
                e.psrc0 = s0;
                e.psrc1 = s1;
                e.pdst = d;
                e.dstWe = we[0];
                e.causeExc = ex[0];
                e.valid = 1'b1;
                expQ.push_back(e);
                if (e.kind == frontSlicePkg::uOpMulLo) begin
                    pauseBudget++; // each multiply pauses at most once.
                end
            end else begin
                n = $fgets(rest, fd); // comment.
            end
        end
        $fclose(fd);
    endtask

    // holds the pair until a cycle with inReady high takes it.
    task automatic sendPair(frontSlicePkg::instrPair p);
        bit taken;
        taken = 1'b0;
        while (!taken) begin
            stallIn = ($urandom % 6) == 0;
            inPair = p;
            #4;
            taken = inReady;
            @(posedge clk);
            #1;
        end
        inPair = '0;
        stallIn = 1'b0;
    endtask

    task automatic flushPulse();
        flushIn = 1'b1;
        @(posedge clk);
        #1;
        flushIn = 1'b0;
        @(negedge clk);
        checkIdle(outPair);
        @(posedge clk);
        #1;
    endtask

    always @(negedge clk) begin
        if (started) begin
            if (prevStall) begin
                checkHold(outPair, lastOut);
            end else begin
                if (outPair.slot0.valid) begin
                    takeOp(outPair.slot0);
                end
                if (outPair.slot1.valid) begin
                    takeOp(outPair.slot1);
                end
            end
            if (seenReady && !stallIn && !prevStall && !flushIn) begin
                // only a single merge pause may hold input back here.
                if (prevPauseLow || pauseCount >= pauseBudget) begin
                    checkReady(inReady, 1'b1);
                end
                prevPauseLow = !inReady;
                if (!inReady) begin
                    pauseCount++;
                end
            end else begin
                prevPauseLow = 1'b0;
            end
            if (inReady) begin
                seenReady = 1'b1;
            end
            lastOut = outPair;
            prevStall = stallIn;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("timeout after %0d cycles with %0d of %0d ops seen",
                cycleCount, gotCount, expQ.size());
            $display("Regression failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        void'($urandom(32'h31c8b33d));
        rstN = 1'b0;
        inPair = '0;
        flushIn = 1'b0;
        stallIn = 1'b0;
        readCases();
        cycleLimit = 8 * inQ.size() + 200;
        repeat (10) @(posedge clk);
        #1;
        rstN = 1'b1;
        started = 1'b1;
        for (int i = 0; i < inQ.size(); i++) begin
            if (flushQ[i]) begin
                while (gotCount < drainQ[i]) begin
                    @(posedge clk);
                    #1;
                end
                sendPair(inQ[i]);
                @(posedge clk); // pair moves into the merge stage.
                #1;
                flushPulse(); // kills the pair before rename.
            end else begin
                sendPair(inQ[i]);
            end
        end
        while (gotCount < expQ.size()) begin
            @(posedge clk);
        end
        repeat (6) @(posedge clk);
        $display("Regression passed");
        $finish;
    end

endmodule

// File: frontSlice.f
+incdir+hdl
hdl/frontSlicePkg.sv
hdl/instrDecoder.sv
hdl/decodeRenameRegs.sv
hdl/tagCounter.sv
hdl/renameMap.sv
hdl/pipeCtrl.sv
hdl/frontSlice.sv
dv/frontSliceTb.sv

// File: Bender.yml
package:
  name: frontSlice

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/frontSlicePkg.sv
      - hdl/instrDecoder.sv
      - hdl/decodeRenameRegs.sv
      - hdl/tagCounter.sv
      - hdl/renameMap.sv
      - hdl/pipeCtrl.sv
      - hdl/frontSlice.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - dv/frontSliceTb.sv

// File: dv/frontSlice_cases.txt
# I/F instr0 instr1 valid0 valid1 (F flushes the pair after it is taken)
# E kind psrc0 psrc1 pdst dstWe causeExc
I 00221821 8ca40008 1 1
E 0 1 2 34 1 0
E 2 5 0 35 1 0
I 24660001 00863821 1 1
E 1 34 0 36 1 0
E 0 35 36 37 1 0
I 00220018 acc70000 1 1
E 5 1 2 38 1 0
E 6 1 2 39 1 0
E 3 36 37 0 0 0
I 10640004 00c70018 1 1
E 4 34 35 0 0 0
E 7 0 0 0 0 0
E 5 36 37 40 1 0
E 6 36 37 41 1 0
I fc200000 00000000 1 0
E 0 1 0 0 0 1
F 00224021 00224821 1 1
I 00645021 01475821 1 1
E 0 34 35 42 1 0
E 0 42 37 43 1 0
I 240c0001 240d0001 1 1
E 1 0 0 44 1 0
E 1 0 0 45 1 0
I 240e0001 240f0001 1 1
E 1 0 0 46 1 0
E 1 0 0 47 1 0
I 24100001 24110001 1 1
E 1 0 0 48 1 0
E 1 0 0 49 1 0
I 24120001 24130001 1 1
E 1 0 0 50 1 0
E 1 0 0 51 1 0
I 24140001 24150001 1 1
E 1 0 0 52 1 0
E 1 0 0 53 1 0
I 24160001 24170001 1 1
E 1 0 0 54 1 0
E 1 0 0 55 1 0
I 24180001 24190001 1 1
E 1 0 0 56 1 0
E 1 0 0 57 1 0
I 241a0001 241b0001 1 1
E 1 0 0 58 1 0
E 1 0 0 59 1 0
I 241c0001 241d0001 1 1
E 1 0 0 60 1 0
E 1 0 0 61 1 0
I 241e0001 241f0001 1 1
E 1 0 0 62 1 0
E 1 0 0 63 1 0
I 019f0821 002d1021 1 1
E 0 44 63 34 1 0
E 0 34 45 35 1 0
